// File: design/mbox_cfg.svh
`ifndef MBOX_CFG_SVH
`define MBOX_CFG_SVH

// ------------------------------------------------------------
// mailbox build configuration
// ------------------------------------------------------------

// words per mailbox FIFO, at least 2
`define MBOX_DEPTH 8

// register word width
`define MBOX_DATA_W 32

// register index width
`define MBOX_ADDR_W 4

`endif

// File: design/mbox_fifo_pkg.sv
`default_nettype none

`include "mbox_cfg.svh"

// types shared by the mailbox FIFOs and their users
package mbox_fifo_pkg;

  // one mailbox word
  typedef logic [`MBOX_DATA_W-1:0] mbox_data_t;

  // fill count 0..depth, one bit wider than the pointer
  typedef logic [$clog2(`MBOX_DEPTH):0] mbox_usage_t;

endpackage

`default_nettype wire

// File: design/mbox_reg_pkg.sv
`default_nettype none

`include "mbox_cfg.svh"

// register map of one mailbox port
package mbox_reg_pkg;

  localparam int unsigned MBOX_NUM_REGS = 10; // indices at or above this are invalid

  typedef enum logic [`MBOX_ADDR_W-1:0] {
    MBOXW  = `MBOX_ADDR_W'd0, // mailbox write
    MBOXR  = `MBOX_ADDR_W'd1, // mailbox read
    STATUS = `MBOX_ADDR_W'd2, // read only
    ERROR  = `MBOX_ADDR_W'd3, // clear on read
    WIRQT  = `MBOX_ADDR_W'd4, // write threshold
    RIRQT  = `MBOX_ADDR_W'd5, // read threshold
    IRQS   = `MBOX_ADDR_W'd6, // irq status, write one to ack
    IRQEN  = `MBOX_ADDR_W'd7, // irq enable
    IRQP   = `MBOX_ADDR_W'd8, // irq pending, read only
    CTRL   = `MBOX_ADDR_W'd9  // fifo flush
  } mbox_reg_e;

  // ------------------------------------------------------------
  // write word as seen by IRQS, IRQEN and CTRL
  // ------------------------------------------------------------
  typedef struct packed {
    logic [`MBOX_DATA_W-4:0] rsvd; // ignored
    logic                    err;  // error irq
    logic                    rd;   // read side, read fifo flush on CTRL
    logic                    wr;   // write side, write fifo flush on CTRL
  } mbox_ctl_bits_t;

  // same word, decoded as a value or as control bits
  typedef union packed {
    logic [`MBOX_DATA_W-1:0] word; // thresholds and mailbox data
    mbox_ctl_bits_t          ctl;  // irq and flush bits
  } mbox_wword_u;

  // fixed read patterns
  localparam logic [`MBOX_DATA_W-1:0] MBOX_WO_PATTERN    = 32'hFEEDC0DE; // MBOXW read
  localparam logic [`MBOX_DATA_W-1:0] MBOX_EMPTY_PATTERN = 32'hFEEDDEAD; // empty MBOXR read

endpackage

`default_nettype wire

// File: design/mbox_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "mbox_cfg.svh"

module mbox_fifo import mbox_fifo_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        flush_i,  // empties the buffer, beats push and pop
  input  logic        push_i,
  input  mbox_data_t  wdata_i,
  input  logic        pop_i,
  output mbox_data_t  rdata_o,  // head word, valid while not empty
  output logic        full_o,
  output logic        empty_o,
  output mbox_usage_t usage_o
);

  localparam int unsigned      PTR_W    = $clog2(`MBOX_DEPTH);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`MBOX_DEPTH - 1);

  mbox_data_t       mem [`MBOX_DEPTH]; // circular storage
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  mbox_usage_t      usage_q;
  logic             do_push, do_pop;

  // wrap at depth, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (usage_q == mbox_usage_t'(`MBOX_DEPTH));
  assign empty_o = (usage_q == '0);
  assign usage_o = usage_q;
  assign rdata_o = mem[rd_ptr]; // head is visible without a pop

  assign do_push = push_i & ~full_o;  // push on full is dropped
  assign do_pop  = pop_i  & ~empty_o; // pop on empty is dropped

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      usage_q <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   usage_q <= usage_q + 1'b1;
        2'b01:   usage_q <= usage_q - 1'b1;
        default: ; // both or none, count holds
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr] <= wdata_i;
  end

endmodule

`default_nettype wire

// File: design/mbox_port_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mbox_cfg.svh"

module mbox_port_decode import mbox_reg_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_i,    // one cycle strobe
  input  logic                    we_i,
  input  logic [`MBOX_ADDR_W-1:0] addr_i,   // register index
  input  logic [`MBOX_DATA_W-1:0] wdata_i,
  output logic                    d_valid_o,
  output logic                    d_we_o,
  output mbox_reg_e               d_reg_o,
  output logic                    d_ok_o,   // index names a register
  output mbox_wword_u             d_wdata_o
);

  // request strobe
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      d_valid_o <= 1'b0;
    end else begin
      d_valid_o <= req_i;
    end
  end

  // ------------------------------------------------------------
  // request payload, only meaningful with d_valid_o
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      d_we_o         <= we_i;
      d_reg_o        <= mbox_reg_e'(addr_i); // out of range values kept, d_ok_o flags them
      d_ok_o         <= (addr_i < `MBOX_ADDR_W'(MBOX_NUM_REGS));
      d_wdata_o.word <= wdata_i;             // execute picks word or ctl view
    end
  end

endmodule

`default_nettype wire

// File: design/mbox_port_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "mbox_cfg.svh"

module mbox_port_exec import mbox_fifo_pkg::*, mbox_reg_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  // from decode
  input  logic        d_valid_i,
  input  logic        d_we_i,
  input  mbox_reg_e   d_reg_i,
  input  logic        d_ok_i,
  input  mbox_wword_u d_wdata_i,
  // fifo state, as it stood before this edge
  input  logic        w_full_i,
  input  mbox_usage_t w_usage_i,
  input  logic        r_empty_i,
  input  mbox_usage_t r_usage_i,
  // fifo control
  output logic        push_o,
  output logic        pop_o,
  output logic        w_flush_o,
  output logic        r_flush_o,
  // towards result
  output logic        e_valid_o,
  output logic        e_we_o,
  output mbox_reg_e   e_reg_o,
  output logic        e_err_o,
  output logic [3:0]  status_o, // {rd thr, wr thr, wr full, rd empty}
  output logic [1:0]  error_o,  // {write on full, read on empty}
  output mbox_data_t  wirqt_o,
  output mbox_data_t  rirqt_o,
  output logic [2:0]  irqs_o,   // {err, rd, wr}
  output logic [2:0]  irqen_o,
  output logic        irq_o
);

  localparam mbox_data_t THR_MAX = mbox_data_t'(`MBOX_DEPTH - 1); // threshold ceiling

  logic [1:0] error_q, error_d;
  mbox_data_t wirqt_q, wirqt_d;
  mbox_data_t rirqt_q, rirqt_d;
  logic [2:0] irqs_q,  irqs_d;
  logic [2:0] irqen_q, irqen_d;
  logic [2:0] irqs_ack;  // ones written to IRQS
  logic       fault;     // full or empty access
  logic       ro_wr;     // write to a read only register

  // usage strictly above threshold, so THR_MAX still fires on full
  assign status_o = {mbox_data_t'(r_usage_i) > rirqt_q,
                     mbox_data_t'(w_usage_i) > wirqt_q,
                     w_full_i,
                     r_empty_i};

  // ------------------------------------------------------------
  // operation execute
  // ------------------------------------------------------------
  always_comb begin
    push_o    = 1'b0;
    pop_o     = 1'b0;
    w_flush_o = 1'b0;
    r_flush_o = 1'b0;
    fault     = 1'b0;
    ro_wr     = 1'b0;
    irqs_ack  = '0;
    error_d   = error_q;
    wirqt_d   = wirqt_q;
    rirqt_d   = rirqt_q;
    irqen_d   = irqen_q;
    irqs_d    = irqs_q | {1'b0, status_o[3], status_o[2]}; // threshold conditions

    if (d_valid_i && d_ok_i) begin
      case (d_reg_i)
        MBOXW: begin
          if (d_we_i && !w_full_i) begin
            push_o = 1'b1;
          end else if (d_we_i) begin
            error_d[1] = 1'b1; // write on full
            irqs_d[2]  = 1'b1;
            fault      = 1'b1;
          end
        end
        MBOXR: begin
          if (d_we_i) begin
            ro_wr = 1'b1;
          end else if (!r_empty_i) begin
            pop_o = 1'b1;
          end else begin
            error_d[0] = 1'b1; // read on empty
            irqs_d[2]  = 1'b1;
            fault      = 1'b1;
          end
        end
        STATUS, IRQP: ro_wr = d_we_i;
        ERROR: begin
          if (d_we_i) ro_wr = 1'b1;
          else        error_d = '0; // cleared by its read
        end
        WIRQT: if (d_we_i) wirqt_d = (d_wdata_i.word > THR_MAX) ? THR_MAX : d_wdata_i.word;
        RIRQT: if (d_we_i) rirqt_d = (d_wdata_i.word > THR_MAX) ? THR_MAX : d_wdata_i.word;
        IRQS: begin
          if (d_we_i) irqs_ack = {d_wdata_i.ctl.err, d_wdata_i.ctl.rd, d_wdata_i.ctl.wr};
        end
        IRQEN: begin
          if (d_we_i) irqen_d = {d_wdata_i.ctl.err, d_wdata_i.ctl.rd, d_wdata_i.ctl.wr};
        end
        CTRL: begin
          if (d_we_i) begin
            r_flush_o = d_wdata_i.ctl.rd;
            w_flush_o = d_wdata_i.ctl.wr;
          end
        end
        default: ;
      endcase
    end

    irqs_d = irqs_d & ~irqs_ack; // ack beats a set in the same cycle
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      error_q <= '0;
      wirqt_q <= '0;
      rirqt_q <= '0;
      irqs_q  <= '0;
      irqen_q <= '0;
    end else begin
      error_q <= error_d;
      wirqt_q <= wirqt_d;
      rirqt_q <= rirqt_d;
      irqs_q  <= irqs_d;
      irqen_q <= irqen_d;
    end
  end

  // pass through to result, response registered there
  assign e_valid_o = d_valid_i;
  assign e_we_o    = d_we_i;
  assign e_reg_o   = d_reg_i;
  assign e_err_o   = d_valid_i & (~d_ok_i | fault | ro_wr);

  assign error_o = error_q;
  assign wirqt_o = wirqt_q;
  assign rirqt_o = rirqt_q;
  assign irqs_o  = irqs_q;
  assign irqen_o = irqen_q;
  assign irq_o   = |(irqs_q & irqen_q); // level, from registers only

endmodule

`default_nettype wire

// File: design/mbox_port_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "mbox_cfg.svh"

module mbox_port_result import mbox_fifo_pkg::*, mbox_reg_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       e_valid_i,
  input  logic       e_we_i,
  input  mbox_reg_e  e_reg_i,
  input  logic       e_err_i,
  input  mbox_data_t pop_data_i,  // head of the read fifo
  input  logic [3:0] status_i,
  input  logic [1:0] error_i,
  input  mbox_data_t wirqt_i,
  input  mbox_data_t rirqt_i,
  input  logic [2:0] irqs_i,
  input  logic [2:0] irqen_i,
  output logic       rsp_valid_o,
  output mbox_data_t rdata_o,
  output logic       rsp_err_o
);

  mbox_data_t rdata_d;

  // ------------------------------------------------------------
  // read data select with zero for writes and bad indices
  // ------------------------------------------------------------
  always_comb begin
    rdata_d = '0;
    if (!e_we_i) begin
      case (e_reg_i)
        MBOXW:   rdata_d = MBOX_WO_PATTERN;
        MBOXR:   rdata_d = e_err_i ? MBOX_EMPTY_PATTERN : pop_data_i; // err here means empty
        STATUS:  rdata_d = mbox_data_t'(status_i);
        ERROR:   rdata_d = mbox_data_t'(error_i); // value before the clear
        WIRQT:   rdata_d = wirqt_i;
        RIRQT:   rdata_d = rirqt_i;
        IRQS:    rdata_d = mbox_data_t'(irqs_i);
        IRQEN:   rdata_d = mbox_data_t'(irqen_i);
        IRQP:    rdata_d = mbox_data_t'(irqs_i & irqen_i);
        default: rdata_d = '0; // CTRL flushes are pulses with nothing to read back
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
      rsp_err_o   <= 1'b0;
    end else begin
      rsp_valid_o <= e_valid_i;
      rsp_err_o   <= e_err_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (e_valid_i) rdata_o <= rdata_d;
  end

endmodule

`default_nettype wire

// File: design/mbox_dual.sv
`timescale 1ns/1ps
`default_nettype none

`include "mbox_cfg.svh"

module mbox_dual import mbox_fifo_pkg::*, mbox_reg_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // port 0
  input  logic                    req_0_i,
  input  logic                    we_0_i,
  input  logic [`MBOX_ADDR_W-1:0] addr_0_i,
  input  logic [`MBOX_DATA_W-1:0] wdata_0_i,
  output logic                    rsp_valid_0_o,
  output logic [`MBOX_DATA_W-1:0] rdata_0_o,
  output logic                    rsp_err_0_o,
  output logic                    irq_0_o,
  // port 1
  input  logic                    req_1_i,
  input  logic                    we_1_i,
  input  logic [`MBOX_ADDR_W-1:0] addr_1_i,
  input  logic [`MBOX_DATA_W-1:0] wdata_1_i,
  output logic                    rsp_valid_1_o,
  output logic [`MBOX_DATA_W-1:0] rdata_1_o,
  output logic                    rsp_err_1_o,
  output logic                    irq_1_o
);

  // index is the port, or for fifo state the writing port (0 is a2b, 1 is b2a)
  logic [1:0] req, we, d_valid, d_we, d_ok, e_valid, e_we, e_err;
  logic [1:0] push, pop, w_flush, r_flush, full, empty, rsp_valid, rsp_err, irq;
  logic [`MBOX_ADDR_W-1:0] addr [2];
  mbox_data_t  wdata [2], fifo_rdata [2], rdata [2], wirqt [2], rirqt [2];
  mbox_reg_e   d_reg [2], e_reg [2];
  mbox_wword_u d_wdata [2];
  mbox_usage_t usage [2];
  logic [3:0]  status [2];
  logic [1:0]  error [2];
  logic [2:0]  irqs [2], irqen [2];

  assign req   = {req_1_i, req_0_i};
  assign we    = {we_1_i, we_0_i};
  assign addr  = '{addr_0_i, addr_1_i};
  assign wdata = '{wdata_0_i, wdata_1_i};

  assign {rsp_valid_1_o, rsp_valid_0_o} = rsp_valid;
  assign {rsp_err_1_o, rsp_err_0_o}     = rsp_err;
  assign {irq_1_o, irq_0_o}             = irq;
  assign rdata_0_o = rdata[0];
  assign rdata_1_o = rdata[1];

  // ------------------------------------------------------------
  // per port pipeline, writes fifo k and reads fifo 1-k
  // ------------------------------------------------------------
  for (genvar k = 0; k < 2; k++) begin : gen_port
    mbox_port_decode i_decode (
      .clk_i, .rst_i,
      .req_i (req[k]), .we_i (we[k]), .addr_i (addr[k]), .wdata_i (wdata[k]),
      .d_valid_o (d_valid[k]), .d_we_o (d_we[k]), .d_reg_o (d_reg[k]),
      .d_ok_o (d_ok[k]), .d_wdata_o (d_wdata[k])
    );

    mbox_port_exec i_exec (
      .clk_i, .rst_i,
      .d_valid_i (d_valid[k]), .d_we_i (d_we[k]), .d_reg_i (d_reg[k]),
      .d_ok_i (d_ok[k]), .d_wdata_i (d_wdata[k]),
      .w_full_i (full[k]), .w_usage_i (usage[k]),
      .r_empty_i (empty[1-k]), .r_usage_i (usage[1-k]),
      .push_o (push[k]), .pop_o (pop[k]), .w_flush_o (w_flush[k]), .r_flush_o (r_flush[k]),
      .e_valid_o (e_valid[k]), .e_we_o (e_we[k]), .e_reg_o (e_reg[k]), .e_err_o (e_err[k]),
      .status_o (status[k]), .error_o (error[k]), .wirqt_o (wirqt[k]), .rirqt_o (rirqt[k]),
      .irqs_o (irqs[k]), .irqen_o (irqen[k]), .irq_o (irq[k])
    );

    mbox_port_result i_result (
      .clk_i, .rst_i,
      .e_valid_i (e_valid[k]), .e_we_i (e_we[k]), .e_reg_i (e_reg[k]), .e_err_i (e_err[k]),
      .pop_data_i (fifo_rdata[1-k]), .status_i (status[k]), .error_i (error[k]),
      .wirqt_i (wirqt[k]), .rirqt_i (rirqt[k]), .irqs_i (irqs[k]), .irqen_i (irqen[k]),
      .rsp_valid_o (rsp_valid[k]), .rdata_o (rdata[k]), .rsp_err_o (rsp_err[k])
    );

    // fifo k, flushed by its writer or by its reader
    mbox_fifo i_fifo (
      .clk_i, .rst_i,
      .flush_i (w_flush[k] | r_flush[1-k]),
      .push_i (push[k]), .wdata_i (d_wdata[k].word), .pop_i (pop[1-k]),
      .rdata_o (fifo_rdata[k]), .full_o (full[k]), .empty_o (empty[k]), .usage_o (usage[k])
    );
  end

endmodule

`default_nettype wire

// File: bench/mbox_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mbox_asserts (
  input logic clk_i,
  input logic rst_i,
  input logic req_0_i,
  input logic req_1_i,
  input logic rsp_valid_0_i,
  input logic rsp_valid_1_i,
  input logic rsp_err_0_i,
  input logic rsp_err_1_i,
  input logic irq_0_i,
  input logic irq_1_i
);

  int unsigned fail_cnt = 0; // read by the testbench at the end of the run

  // ------------------------------------------------------------
  // fixed two cycle response latency
  // ------------------------------------------------------------
  rsp_lat_0: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_0_i == $past(req_0_i, 2))
    else begin
      $error("port 0 response not two cycles after its request");
      fail_cnt++;
    end

  rsp_lat_1: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_1_i == $past(req_1_i, 2))
    else begin
      $error("port 1 response not two cycles after its request");
      fail_cnt++;
    end

  // error flag rides on a response only
  err_valid_0: assert property (@(posedge clk_i) rsp_err_0_i |-> rsp_valid_0_i)
    else begin
      $error("port 0 rsp_err without rsp_valid");
      fail_cnt++;
    end

  err_valid_1: assert property (@(posedge clk_i) rsp_err_1_i |-> rsp_valid_1_i)
    else begin
      $error("port 1 rsp_err without rsp_valid");
      fail_cnt++;
    end

  // irq registers come out of reset cleared
  irq_after_rst: assert property (@(posedge clk_i) $fell(rst_i) |-> !irq_0_i && !irq_1_i)
    else begin
      $error("irq high in the cycle after reset");
      fail_cnt++;
    end

endmodule

bind mbox_dual mbox_asserts mbox_asserts_i (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .req_0_i       (req_0_i),
  .req_1_i       (req_1_i),
  .rsp_valid_0_i (rsp_valid_0_o),
  .rsp_valid_1_i (rsp_valid_1_o),
  .rsp_err_0_i   (rsp_err_0_o),
  .rsp_err_1_i   (rsp_err_1_o),
  .irq_0_i       (irq_0_o),
  .irq_1_i       (irq_1_o)
);

`default_nettype wire

// File: bench/mbox_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mbox_cfg.svh"

module mbox_tb import mbox_reg_pkg::*; ();

  localparam logic [31:0] WO_WORD     = 32'hFEEDC0DE; // MBOXW read back
  localparam logic [31:0] EMPTY_WORD  = 32'hFEEDDEAD; // MBOXR on an empty mailbox
  localparam int unsigned THR_MAX     = `MBOX_DEPTH - 1;
  localparam int          NUM_CYCLES  = 1500;
  localparam int          DRAIN_LIMIT = 10;          // cycles allowed to empty the pipeline

  typedef struct packed {
    logic                    req;
    logic                    we;
    logic [`MBOX_ADDR_W-1:0] addr;
    logic [`MBOX_DATA_W-1:0] wdata;
  } req_t;

  logic                    clk, rst;
  logic                    req [2];
  logic                    we [2];
  logic [`MBOX_ADDR_W-1:0] addr [2];
  logic [`MBOX_DATA_W-1:0] wdata [2];
  logic                    rsp_valid [2];
  logic [`MBOX_DATA_W-1:0] rdata [2];
  logic                    rsp_err [2];
  logic                    irq [2];

  // ------------------------------------------------------------
  // reference model state
  // ------------------------------------------------------------
  logic [31:0] fifo_q [2][$];  // fifo k is written by port k
  logic [1:0]  m_error [2];
  logic [31:0] m_wirqt [2];
  logic [31:0] m_rirqt [2];
  logic [2:0]  m_irqs [2];     // {err, rd, wr}
  logic [2:0]  m_irqen [2];
  req_t        stage1 [2];     // captured by decode at the last edge
  req_t        stage2 [2];     // executed at this edge
  logic        exp_valid [2];
  logic [31:0] exp_data [2];
  logic        exp_err [2];
  logic        exp_irq [2];
  int          errors;
  int          n_checks;

  mbox_dual mbox_dual_i (
    .clk_i (clk), .rst_i (rst),
    .req_0_i (req[0]), .we_0_i (we[0]), .addr_0_i (addr[0]), .wdata_0_i (wdata[0]),
    .rsp_valid_0_o (rsp_valid[0]), .rdata_0_o (rdata[0]), .rsp_err_0_o (rsp_err[0]),
    .irq_0_o (irq[0]),
    .req_1_i (req[1]), .we_1_i (we[1]), .addr_1_i (addr[1]), .wdata_1_i (wdata[1]),
    .rsp_valid_1_o (rsp_valid[1]), .rdata_1_o (rdata[1]), .rsp_err_1_o (rsp_err[1]),
    .irq_1_o (irq[1])
  );

  always #10 clk = ~clk; // 20 ns period

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // one edge of the model, both ports against the state before it
  task automatic model_step();
    logic [3:0]  st [2];
    logic [2:0]  nirqs [2];
    logic [2:0]  ack [2];
    logic        push [2];
    logic        pop [2];
    logic        wfl [2];
    logic        rfl [2];
    logic [31:0] wuse, ruse;
    req_t        r;
    int          p, o;
    for (p = 0; p < 2; p++) begin
      o        = 1 - p;
      r        = stage2[p];
      wuse     = fifo_q[p].size();
      ruse     = fifo_q[o].size();
      st[p]    = {ruse > m_rirqt[p], wuse > m_wirqt[p], wuse == `MBOX_DEPTH, ruse == 0};
      nirqs[p] = m_irqs[p] | {1'b0, st[p][3], st[p][2]}; // threshold set every cycle
      ack[p]   = '0;
      push[p]  = 1'b0;
      pop[p]   = 1'b0;
      wfl[p]   = 1'b0;
      rfl[p]   = 1'b0;
      exp_valid[p] = r.req;
      exp_err[p]   = 1'b0;
      exp_data[p]  = '0;   // writes and bad indices read as zero
      if (r.req && r.addr > CTRL) begin
        exp_err[p] = 1'b1;
      end else if (r.req) begin
        case (r.addr)
          MBOXW: begin
            if (!r.we) begin
              exp_data[p] = WO_WORD;
            end else if (wuse == `MBOX_DEPTH) begin
              exp_err[p]    = 1'b1; // mailbox full
              m_error[p][1] = 1'b1;
              nirqs[p][2]   = 1'b1;
            end else begin
              push[p] = 1'b1;
            end
          end
          MBOXR: begin
            if (r.we) begin
              exp_err[p] = 1'b1;
            end else if (ruse == 0) begin
              exp_err[p]    = 1'b1;
              exp_data[p]   = EMPTY_WORD;
              m_error[p][0] = 1'b1;
              nirqs[p][2]   = 1'b1;
            end else begin
              pop[p]      = 1'b1;
              exp_data[p] = fifo_q[o][0]; // head of the other port's fifo
            end
          end
          STATUS: begin
            if (r.we) exp_err[p] = 1'b1;
            else      exp_data[p] = 32'(st[p]);
          end
          ERROR: begin
            if (r.we) begin
              exp_err[p] = 1'b1;
            end else begin
              exp_data[p] = 32'(m_error[p]);
              m_error[p]  = '0; // clear on read
            end
          end
          WIRQT: begin
            if (r.we) m_wirqt[p] = (r.wdata > THR_MAX) ? THR_MAX : r.wdata;
            else      exp_data[p] = m_wirqt[p];
          end
          RIRQT: begin
            if (r.we) m_rirqt[p] = (r.wdata > THR_MAX) ? THR_MAX : r.wdata;
            else      exp_data[p] = m_rirqt[p];
          end
          IRQS: begin
            if (r.we) ack[p] = r.wdata[2:0];
            else      exp_data[p] = 32'(m_irqs[p]);
          end
          IRQEN: begin
            if (r.we) m_irqen[p] = r.wdata[2:0];
            else      exp_data[p] = 32'(m_irqen[p]);
          end
          IRQP: begin
            if (r.we) exp_err[p] = 1'b1;
            else      exp_data[p] = 32'(m_irqs[p] & m_irqen[p]);
          end
          default: begin
            if (r.we) begin
              rfl[p] = r.wdata[1]; // CTRL flush bits
              wfl[p] = r.wdata[0];
            end
          end
        endcase
      end
    end
    for (p = 0; p < 2; p++) begin
      m_irqs[p] = nirqs[p] & ~ack[p]; // ack wins over a set
    end
    // fifo p: written by port p, read by the other port
    for (p = 0; p < 2; p++) begin
      if (wfl[p] || rfl[1-p]) begin
        fifo_q[p].delete();
      end else begin
        if (pop[1-p]) void'(fifo_q[p].pop_front());
        if (push[p])  fifo_q[p].push_back(stage2[p].wdata);
      end
    end
    for (p = 0; p < 2; p++) begin
      exp_irq[p] = |(m_irqs[p] & m_irqen[p]);
    end
  endtask

  task automatic check_outputs();
    int p;
    for (p = 0; p < 2; p++) begin
      compare(32'(rsp_valid[p]), 32'(exp_valid[p]), $sformatf("port %0d rsp_valid", p));
      if (exp_valid[p]) begin
        compare(rdata[p], exp_data[p], $sformatf("port %0d rdata", p));
        compare(32'(rsp_err[p]), 32'(exp_err[p]), $sformatf("port %0d rsp_err", p));
      end
      compare(32'(irq[p]), 32'(exp_irq[p]), $sformatf("port %0d irq", p));
    end
  endtask

  // mostly mailbox traffic, wr_pct sets the write share of it
  function automatic req_t random_request(input int wr_pct);
    req_t r;
    r       = '0;
    r.req   = ($urandom % 100) < 85;
    r.wdata = $urandom;
    if (($urandom % 100) < 70) begin
      r.we   = ($urandom % 100) < wr_pct;
      r.addr = r.we ? MBOXW : MBOXR;
    end else begin
      r.addr = `MBOX_ADDR_W'($urandom % 16); // invalid indices too
      r.we   = 1'($urandom % 2);
      if (r.addr == WIRQT || r.addr == RIRQT) r.wdata = $urandom % 12; // some above the clamp
    end
    return r;
  endfunction

  // edge, check, then drive the next requests 1 ns later
  task automatic run_cycle(input req_t nxt0, input req_t nxt1);
    @(posedge clk);
    #1;
    model_step();
    check_outputs();
    stage2 = stage1;
    stage1 = '{nxt0, nxt1};
    req    = '{nxt0.req, nxt1.req};
    we     = '{nxt0.we, nxt1.we};
    addr   = '{nxt0.addr, nxt1.addr};
    wdata  = '{nxt0.wdata, nxt1.wdata};
  endtask

  initial begin
    req_t idle;
    int   cyc;
    int   wr_pct;
    int   drain;
    logic draining;
    void'($urandom(49237));
    idle     = '0;
    errors   = 0;
    n_checks = 0;
    clk      = 1'b0;
    rst      = 1'b1;
    req      = '{1'b0, 1'b0};
    we       = '{1'b0, 1'b0};
    addr     = '{'0, '0};
    wdata    = '{'0, '0};
    stage1   = '{idle, idle};
    stage2   = '{idle, idle};
    m_error  = '{'0, '0};
    m_wirqt  = '{'0, '0};
    m_rirqt  = '{'0, '0};
    m_irqs   = '{'0, '0};
    m_irqen  = '{'0, '0};

    repeat (3) @(posedge clk); // reset over three edges
    #1 rst = 1'b0;

    // ------------------------------------------------------------
    // phases: balanced, fill to full, drain to empty, balanced
    // ------------------------------------------------------------
    for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      if (cyc < 400)       wr_pct = 50;
      else if (cyc < 700)  wr_pct = 85;
      else if (cyc < 1000) wr_pct = 15;
      else                 wr_pct = 50;
      run_cycle(random_request(wr_pct), random_request(wr_pct));
    end

    // let the last requests come back
    drain    = 0;
    draining = 1'b1;
    while (draining) begin
      run_cycle(idle, idle);
      drain++;
      if (!stage1[0].req && !stage1[1].req && !stage2[0].req && !stage2[1].req &&
          !rsp_valid[0] && !rsp_valid[1]) begin
        draining = 1'b0;
      end else if (drain >= DRAIN_LIMIT) begin
        $display("timeout: responses still pending after %0d idle cycles", DRAIN_LIMIT);
        errors++;
        draining = 1'b0;
      end
    end

    errors += mbox_dual_i.mbox_asserts_i.fail_cnt;
    $display("errors: %0d  checks: %0d  assertion failures: %0d",
             errors, n_checks, mbox_dual_i.mbox_asserts_i.fail_cnt);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
design/mbox_fifo_pkg.sv
design/mbox_reg_pkg.sv
design/mbox_fifo.sv
design/mbox_port_decode.sv
design/mbox_port_exec.sv
design/mbox_port_result.sv
design/mbox_dual.sv
bench/mbox_asserts.sv
bench/mbox_tb.sv
